// File: rtl/uart_pkg.sv
// Shared widths, defaults and state encodings for the UART core

package uart_pkg;

	// ------------------------------------------------------------
	// Widths and defaults
	// ------------------------------------------------------------

	// Bit period counter width, also the width of baud_div
	localparam int BAUD_W = 16;

	// Widest frame payload, ports are sized to this
	localparam int DATA_BITS_DEF = 8;

	// Bit index counter, wide enough for DATA_BITS_DEF bits
	localparam int BIT_IDX_W = $clog2(DATA_BITS_DEF);

	// Below this the mid-bit sample gets too close to the edges
	localparam logic [BAUD_W-1:0] BAUD_DIV_MIN = 16'd4;

	// ------------------------------------------------------------
	// State encodings
	// ------------------------------------------------------------

	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0, // Line high, ready for a byte
		TX_START = 2'd1, // Driving start bit
		TX_DATA  = 2'd2, // Shifting out data, LSB first
		TX_STOP  = 2'd3  // Holding stop bit
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0, // Waiting for a low line
		RX_START = 2'd1, // Start bit, recheck at mid
		RX_DATA  = 2'd2, // Sampling data bits at mid
		RX_STOP  = 2'd3  // Judging stop bit
	} rx_state_e;

endpackage

// File: rtl/uart_baud_timer.sv
`timescale 1ns/100ps

// Bit period timer, one per direction
// Counts 0 .. baud_div-1 while run is high, sits at zero otherwise
module uart_baud_timer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        run,      // High for the whole frame
	input  logic [uart_pkg::BAUD_W-1:0] baud_div, // Clock cycles per bit
	output logic                        bit_end,  // Last cycle of a bit period
	output logic                        mid       // Mid-bit sample point
);

	import uart_pkg::*;

	logic [BAUD_W-1:0] count;
	logic [BAUD_W-1:0] half_div;
	logic              at_last;

	assign half_div = baud_div >> 1; // Rounded down
	assign at_last  = (count == baud_div - 1'b1);

	// ------------------------------------------------------------
	// Counter
	// ------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (!run) begin
			count <= '0; // Held while the direction is idle
		end else if (at_last) begin
			count <= '0; // Wrap at end of bit
		end else begin
			count <= count + 1'b1;
		end
	end

	// Strobes only while running
	assign bit_end = run && at_last;
	assign mid     = run && (count == half_div);

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------

	// Too small a divider breaks the mid/end spacing in both FSMs
	a_baud_div_min: assert property (
		@(posedge clk) disable iff (reset)
		run |-> (baud_div >= BAUD_DIV_MIN)
	) else $error("baud_div below minimum while timer runs");

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/100ps

// UART transmitter
// Start bit, DATA_BITS data bits LSB first, one stop bit
// Bit timing comes from an external uart_baud_timer
module uart_tx #(
	parameter int DATA_BITS = uart_pkg::DATA_BITS_DEF
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               bit_end,   // From timer
	input  logic                               tx_latch,  // Host strobe, may be held
	input  logic [uart_pkg::DATA_BITS_DEF-1:0] tx_data,
	output logic                               tx_out,    // Serial line, idles high
	output logic                               tx_empty,  // Ready for a byte
	output logic                               timer_run
);

	import uart_pkg::*;

	localparam logic [BIT_IDX_W-1:0] LAST_IDX = BIT_IDX_W'(DATA_BITS - 1);

	tx_state_e            state;
	logic [DATA_BITS-1:0] shreg;   // Bits not yet on the line
	logic [BIT_IDX_W-1:0] bit_idx; // Data bit now on the line
	logic                 accept;
	logic                 shift_en;

	// Byte taken only while idle, a latch while busy is dropped
	assign accept = tx_empty && tx_latch;

	// Timer runs for the whole frame
	assign timer_run = (state != TX_IDLE);

	// Next bit moves to shreg[0] each time one goes out
	assign shift_en = bit_end && ((state == TX_START) || (state == TX_DATA));

	// ------------------------------------------------------------
	// Shift register
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (accept) begin
			shreg <= tx_data[DATA_BITS-1:0]; // Upper bits unused for short frames
		end else if (shift_en) begin
			shreg <= {1'b0, shreg[DATA_BITS-1:1]};
		end
	end

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= TX_IDLE;
			tx_out   <= 1'b1;
			tx_empty <= 1'b1;
			bit_idx  <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (accept) begin
						state    <= TX_START;
						tx_out   <= 1'b0; // Start bit from the next cycle
						tx_empty <= 1'b0;
					end
				end

				TX_START: begin
					if (bit_end) begin
						state   <= TX_DATA;
						tx_out  <= shreg[0]; // Bit 0
						bit_idx <= '0;
					end
				end

				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == LAST_IDX) begin
							state  <= TX_STOP;
							tx_out <= 1'b1; // Stop bit
						end else begin
							tx_out  <= shreg[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end

				TX_STOP: begin
					// Ready again on the edge that ends the stop bit
					if (bit_end) begin
						state    <= TX_IDLE;
						tx_empty <= 1'b1;
					end
				end

				default: begin
					state    <= TX_IDLE;
					tx_out   <= 1'b1;
					tx_empty <= 1'b1;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------

	// Line must idle high between frames
	a_idle_line_high: assert property (
		@(posedge clk) disable iff (reset)
		(state == TX_IDLE) |-> tx_out
	) else $error("tx_out low while transmitter idle");

	// Busy only ever follows a host latch
	a_empty_fall_on_accept: assert property (
		@(posedge clk) disable iff (reset)
		$fell(tx_empty) |-> $past(tx_latch)
	) else $error("tx_empty fell without tx_latch");

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/100ps

// UART receiver
// Two-flop synchronizer, one sample per bit at mid-bit
// Start bit rechecked at mid to reject glitches, stop bit judged at mid
module uart_rx #(
	parameter int DATA_BITS = uart_pkg::DATA_BITS_DEF
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               rx_in,        // Async serial line
	input  logic                               mid,          // From timer
	output logic [uart_pkg::DATA_BITS_DEF-1:0] rx_data,      // Last good byte
	output logic                               rx_latch,     // One cycle, good frame
	output logic                               rx_frame_err, // One cycle, stop bit low
	output logic                               timer_run
);

	import uart_pkg::*;

	localparam logic [BIT_IDX_W-1:0] LAST_IDX = BIT_IDX_W'(DATA_BITS - 1);

	rx_state_e            state;
	logic                 rx_meta;   // First sync flop
	logic                 rx_sync;   // Safe to use
	logic                 hold_off;  // First idle cycle after a frame
	logic                 start_det;
	logic [DATA_BITS-1:0] shreg;
	logic [BIT_IDX_W-1:0] bit_idx;

	// ------------------------------------------------------------
	// Synchronizer
	// ------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1; // Line idles high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
		end
	end

	// Low line while idle opens a frame in this very cycle.
	// The timer still holds a stale count right after a frame,
	// so detection waits one cycle for it to clear.
	assign start_det = (state == RX_IDLE) && !rx_sync && !hold_off;

	// Timer count is 0 in the detect cycle, mid lands baud_div/2 later
	assign timer_run = (state != RX_IDLE) || start_det;

	// ------------------------------------------------------------
	// Shift register
	// ------------------------------------------------------------

	// LSB arrives first and walks down to bit 0
	always_ff @(posedge clk) begin
		if ((state == RX_DATA) && mid) begin
			shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
		end
	end

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state        <= RX_IDLE;
			bit_idx      <= '0;
			hold_off     <= 1'b0;
			rx_data      <= '0;
			rx_latch     <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			rx_latch     <= 1'b0; // Strobes
			rx_frame_err <= 1'b0;
			hold_off     <= 1'b0;

			case (state)
				RX_IDLE: begin
					if (start_det) begin
						state <= RX_START;
					end
				end

				RX_START: begin
					if (mid) begin
						if (rx_sync) begin
							// Line back high, just a glitch
							state    <= RX_IDLE;
							hold_off <= 1'b1;
						end else begin
							state   <= RX_DATA;
							bit_idx <= '0;
						end
					end
				end

				RX_DATA: begin
					if (mid) begin
						if (bit_idx == LAST_IDX) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end

				RX_STOP: begin
					// Idle from here, remaining half stop bit can hold a new start
					if (mid) begin
						state    <= RX_IDLE;
						hold_off <= 1'b1;
						if (rx_sync) begin
							rx_latch <= 1'b1;
							rx_data  <= DATA_BITS_DEF'(shreg); // Zero-extend short frames
						end else begin
							rx_frame_err <= 1'b1; // rx_data keeps last good byte
						end
					end
				end

				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------

	// A frame ends either good or bad, never both
	a_strobes_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(rx_latch && rx_frame_err)
	) else $error("rx_latch and rx_frame_err high together");

endmodule

// File: rtl/uart_core.sv
`timescale 1ns/100ps

// UART core top
// One transmitter and one receiver, each with its own bit timer.
// Both timers share baud_div, so both directions run at one rate.
module uart_core #(
	parameter int DATA_BITS = uart_pkg::DATA_BITS_DEF // 5 to 8
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [uart_pkg::BAUD_W-1:0]        baud_div,
	input  logic                               rx_in,
	output logic                               tx_out,
	input  logic                               tx_latch,
	input  logic [uart_pkg::DATA_BITS_DEF-1:0] tx_data,
	output logic                               tx_empty,
	output logic [uart_pkg::DATA_BITS_DEF-1:0] rx_data,
	output logic                               rx_latch,
	output logic                               rx_frame_err
);

	import uart_pkg::*;

	logic tx_bit_end;
	logic tx_timer_run;
	logic rx_mid;
	logic rx_timer_run;

	// Frame length outside what the ports and bit index can carry
	if ((DATA_BITS < 5) || (DATA_BITS > DATA_BITS_DEF)) begin : g_bad_data_bits
		$error("uart_core: DATA_BITS out of range");
	end

	// ------------------------------------------------------------
	// Transmit direction
	// ------------------------------------------------------------

	uart_baud_timer u_tx_timer (
		.clk      (clk),
		.reset    (reset),
		.run      (tx_timer_run),
		.baud_div (baud_div),
		.bit_end  (tx_bit_end),
		.mid      ()             // TX only needs bit ends
	);

	uart_tx #(
		.DATA_BITS (DATA_BITS)
	) u_tx (
		.clk       (clk),
		.reset     (reset),
		.bit_end   (tx_bit_end),
		.tx_latch  (tx_latch),
		.tx_data   (tx_data),
		.tx_out    (tx_out),
		.tx_empty  (tx_empty),
		.timer_run (tx_timer_run)
	);

	// ------------------------------------------------------------
	// Receive direction
	// ------------------------------------------------------------

	uart_baud_timer u_rx_timer (
		.clk      (clk),
		.reset    (reset),
		.run      (rx_timer_run),
		.baud_div (baud_div),
		.bit_end  (),            // RX samples at mid only
		.mid      (rx_mid)
	);

	uart_rx #(
		.DATA_BITS (DATA_BITS)
	) u_rx (
		.clk          (clk),
		.reset        (reset),
		.rx_in        (rx_in),
		.mid          (rx_mid),
		.rx_data      (rx_data),
		.rx_latch     (rx_latch),
		.rx_frame_err (rx_frame_err),
		.timer_run    (rx_timer_run)
	);

endmodule

// File: tests/uart_core_checker.sv
`timescale 1ns/100ps

// Monitor for uart_core
// Decodes tx_out at mid-bit, checks receive strobes, closes each table row
module uart_core_checker #(
	parameter int DATA_BITS = 8,
	parameter int NAME_W    = 96
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [uart_pkg::BAUD_W-1:0] baud_div,
	input  logic [NAME_W-1:0]           test_name,
	input  logic [7:0]                  exp_tx,        // Byte due on tx_out
	input  logic [7:0]                  exp_rx,        // Byte due with rx_latch
	input  int                          exp_tx_frames, // Frames due this row
	input  logic [1:0]                  exp_rx_kind,   // 0 none, 1 good, 2 frame error
	input  logic                        row_done,      // Close the row
	input  logic                        tx_out,
	input  logic                        tx_empty,
	input  logic [7:0]                  rx_data,
	input  logic                        rx_latch,
	input  logic                        rx_frame_err,
	output int                          errors
);

	localparam logic [1:0] KIND_GOOD = 2'd1;
	localparam logic [1:0] KIND_ERR  = 2'd2;

	int         err_count = 0;
	int         bd;
	logic       reset_q = 1'b1;
	logic       dec_busy;
	int         phase;     // Cycle within the bit
	int         bitn;      // 0 start, then data, then stop
	logic [7:0] dec_byte;  // Fills from the top
	int         frames;
	int         latches;
	int         ferrs;
	int         empty_cnt; // Samples with tx_empty low
	logic       empty_q;
	logic [7:0] prev_good; // Last byte delivered by rx_latch

	assign bd     = int'(baud_div);
	assign errors = err_count;

	task automatic flag_mismatch(input string what, input int expv, input int actv);
		$display("Fail %0s %0s: expected %0h, actual %0h", test_name, what, expv, actv);
		err_count = err_count + 1;
	endtask

	task automatic note_failure(input string msg);
		$display("%0s: %0s", test_name, msg);
		err_count = err_count + 1;
	endtask

	always @(posedge clk) begin
		reset_q <= reset;
		empty_q <= tx_empty;
		if (reset) begin
			dec_busy  <= 1'b0;
			dec_byte  <= 8'h00;
			frames    <= 0;
			latches   <= 0;
			ferrs     <= 0;
			empty_cnt <= 0;
			prev_good <= 8'h00; // rx_data resets to zero
		end else begin
			// First cycle out of reset, nothing driven yet
			if (reset_q && (!tx_out || !tx_empty || rx_latch || rx_frame_err)) begin
				note_failure("outputs not at their reset values after reset");
			end

			// ------------------------------------------------------------
			// tx_out frame decode
			// ------------------------------------------------------------
			if (!dec_busy) begin
				if (!tx_out) begin
					dec_busy <= 1'b1; // Start bit seen
					phase    <= 1;
					bitn     <= 0;
				end
			end else begin
				if (phase == bd / 2) begin
					if (bitn == 0) begin
						if (tx_out) begin
							note_failure("start bit on tx_out not low at mid-bit");
							dec_busy <= 1'b0;
						end
					end else if (bitn <= DATA_BITS) begin
						dec_byte <= {tx_out, dec_byte[7:1]}; // LSB first
					end else begin
						dec_busy <= 1'b0;
						frames   <= frames + 1;
						if (!tx_out) note_failure("stop bit on tx_out not high");
						if ((dec_byte >> (8 - DATA_BITS)) != exp_tx) begin
							flag_mismatch("tx_out frame", int'(exp_tx),
								int'(dec_byte >> (8 - DATA_BITS)));
						end
					end
				end
				if (phase == bd - 1) begin
					phase <= 0;
					bitn  <= bitn + 1;
				end else begin
					phase <= phase + 1;
				end
			end

			// Busy time, start to end of stop bit
			if (!tx_empty) begin
				empty_cnt <= empty_cnt + 1;
			end else if (!empty_q) begin
				if (empty_cnt != (DATA_BITS + 2) * bd) begin
					flag_mismatch("tx_empty low cycles", (DATA_BITS + 2) * bd, empty_cnt);
				end
				empty_cnt <= 0;
			end

			// ------------------------------------------------------------
			// Receive strobes
			// ------------------------------------------------------------
			if (rx_latch) begin
				latches <= latches + 1;
				if (exp_rx_kind != KIND_GOOD) begin
					note_failure("rx_latch where none was due");
				end else if (rx_data != exp_rx) begin
					flag_mismatch("rx_data", int'(exp_rx), int'(rx_data));
				end
			end
			if (rx_frame_err) begin
				ferrs <= ferrs + 1;
				if (exp_rx_kind != KIND_ERR) note_failure("rx_frame_err where none was due");
				if (rx_data != prev_good) begin
					flag_mismatch("rx_data after frame error", int'(prev_good), int'(rx_data));
				end
			end

			// Row totals
			if (row_done) begin
				if (frames != exp_tx_frames) begin
					note_failure($sformatf("%0d tx frames due, %0d seen", exp_tx_frames, frames));
				end
				if (latches != ((exp_rx_kind == KIND_GOOD) ? 1 : 0)) begin
					note_failure($sformatf("wrong number of rx_latch strobes, %0d seen", latches));
				end
				if (ferrs != ((exp_rx_kind == KIND_ERR) ? 1 : 0)) begin
					note_failure($sformatf("wrong number of rx_frame_err strobes, %0d seen", ferrs));
				end
				if (exp_rx_kind == KIND_GOOD) prev_good <= exp_rx;
				frames  <= 0;
				latches <= 0;
				ferrs   <= 0;
			end
		end
	end

endmodule

// File: tests/uart_core_tb.sv
`timescale 1ns/100ps

// Testbench top for uart_core
// One table row per frame, judging done in uart_core_checker
module uart_core_tb;

	localparam int          DATA_BITS = 8;
	localparam int          NAME_W    = 8 * 12; // Twelve-character row names
	localparam int          N_ROWS    = 8;
	localparam logic [31:0] SEED      = 32'h8df2_9d2c;
	localparam logic [7:0]  DATA_MASK = 8'((1 << DATA_BITS) - 1);

	typedef enum logic [1:0] {
		M_LOOP,   // tx_out wired back to rx_in
		M_BAD,    // Bit-banged frame, stop bit low
		M_GLITCH, // Short low pulse, then a good frame
		M_BUSY    // Second tx_latch while busy
	} mode_e;

	logic                        clk;
	logic                        reset;
	logic [uart_pkg::BAUD_W-1:0] baud_div;
	logic                        rx_drv;  // Bit-banged line
	logic                        loop_en;
	logic                        rx_line;
	logic                        tx_out;
	logic                        tx_latch;
	logic [7:0]                  tx_data;
	logic                        tx_empty;
	logic [7:0]                  rx_data;
	logic                        rx_latch;
	logic                        rx_frame_err;

	// Row expectations, to the checker
	logic [NAME_W-1:0] test_name;
	logic [7:0]        exp_tx;
	logic [7:0]        exp_rx;
	int                exp_tx_frames;
	logic [1:0]        exp_rx_kind;
	logic              row_done;
	int                chk_errors;

	// Stimulus table
	logic [NAME_W-1:0]           t_name [N_ROWS];
	logic [uart_pkg::BAUD_W-1:0] t_div  [N_ROWS];
	logic [7:0]                  t_data [N_ROWS]; // 0 takes the next xorshift byte
	mode_e                       t_mode [N_ROWS];

	logic [31:0] rnd            = SEED;
	int          strobe_cnt     = 0;
	int          cycles         = 0;
	int          cycle_limit    = 0; // Filled in from the table
	int          timeout_errors = 0;

	assign rx_line = loop_en ? tx_out : rx_drv;

	uart_core #(
		.DATA_BITS (DATA_BITS)
	) u_uart_core (
		.clk          (clk),
		.reset        (reset),
		.baud_div     (baud_div),
		.rx_in        (rx_line),
		.tx_out       (tx_out),
		.tx_latch     (tx_latch),
		.tx_data      (tx_data),
		.tx_empty     (tx_empty),
		.rx_data      (rx_data),
		.rx_latch     (rx_latch),
		.rx_frame_err (rx_frame_err)
	);

	uart_core_checker #(
		.DATA_BITS (DATA_BITS),
		.NAME_W    (NAME_W)
	) u_checker (
		.clk           (clk),
		.reset         (reset),
		.baud_div      (baud_div),
		.test_name     (test_name),
		.exp_tx        (exp_tx),
		.exp_rx        (exp_rx),
		.exp_tx_frames (exp_tx_frames),
		.exp_rx_kind   (exp_rx_kind),
		.row_done      (row_done),
		.tx_out        (tx_out),
		.tx_empty      (tx_empty),
		.rx_data       (rx_data),
		.rx_latch      (rx_latch),
		.rx_frame_err  (rx_frame_err),
		.errors        (chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic set_row(input logic [2:0] r, input logic [NAME_W-1:0] name,
		input logic [uart_pkg::BAUD_W-1:0] div, input logic [7:0] data, input mode_e mode);
		t_name[r] = name;
		t_div[r]  = div;
		t_data[r] = data;
		t_mode[r] = mode;
	endtask

	// One byte through tx_latch, tx_empty already high
	task automatic send_byte(input logic [7:0] b);
		tx_data  <= b;
		tx_latch <= 1'b1;
		@(posedge clk);
		tx_latch <= 1'b0; // Accepted on this edge
	endtask

	// Full frame on rx_in, LSB first
	task automatic bang_frame(input int bd, input logic [7:0] b, input logic stop_bit);
		logic [7:0] bits;
		bits = b;
		rx_drv <= 1'b0;
		repeat (bd) @(posedge clk);
		repeat (DATA_BITS) begin
			rx_drv <= bits[0];
			bits = bits >> 1;
			repeat (bd) @(posedge clk);
		end
		rx_drv <= stop_bit;
		repeat (bd) @(posedge clk);
		rx_drv <= 1'b1;
	endtask

	task automatic wait_rx_strobe(input int base);
		while (strobe_cnt == base) @(posedge clk);
	endtask

	task automatic wait_tx_ready;
		while (!tx_empty) @(posedge clk);
	endtask

	// Either receive strobe, counted for the row waits
	always @(posedge clk) begin
		if (rx_latch || rx_frame_err) strobe_cnt <= strobe_cnt + 1;
	end

	// ------------------------------------------------------------
	// Timeout
	// ------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
			timeout_errors = timeout_errors + 1;
			$display("Timeout: run did not finish in %0d cycles, stuck in %0s",
				cycle_limit, test_name);
			$display("Errors: checker %0d, timeout %0d", chk_errors, timeout_errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		logic [2:0] ri;
		logic [7:0] b;
		int         bd;
		int         glitch_len;
		int         base;

		reset         <= 1'b1;
		baud_div      <= 16'd16;
		rx_drv        <= 1'b1; // Idle line
		loop_en       <= 1'b0;
		tx_latch      <= 1'b0;
		tx_data       <= 8'h00;
		row_done      <= 1'b0;
		test_name     <= "reset       ";
		exp_tx        <= 8'h00;
		exp_rx        <= 8'h00;
		exp_tx_frames <= 0;
		exp_rx_kind   <= 2'd0;

		set_row(3'd0, "loopback_d04", 16'd4,  8'ha5, M_LOOP);  // Smallest divider
		set_row(3'd1, "loopback_d07", 16'd7,  8'h00, M_LOOP);  // Odd divider
		set_row(3'd2, "loopback_d16", 16'd16, 8'h3c, M_LOOP);
		set_row(3'd3, "bad_stop_d08", 16'd8,  8'h81, M_BAD);
		set_row(3'd4, "glitch_d16  ", 16'd16, 8'h6e, M_GLITCH);
		set_row(3'd5, "busy_d10    ", 16'd10, 8'hc3, M_BUSY);
		set_row(3'd6, "loopback_d05", 16'd5,  8'h00, M_LOOP);
		set_row(3'd7, "bad_stop_d12", 16'd12, 8'h00, M_BAD);

		ri          = 3'd0;
		cycle_limit = 200;
		repeat (N_ROWS) begin
			cycle_limit = cycle_limit + 14 * int'(t_div[ri]);
			ri = ri + 3'd1;
		end

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk); // Checker looks at reset values here

		ri = 3'd0;
		repeat (N_ROWS) begin
			bd = int'(t_div[ri]);
			b  = t_data[ri];
			if (b == 8'h00) begin
				rnd = xorshift32(rnd);
				b   = rnd[7:0];
			end
			b = b & DATA_MASK;

			baud_div      <= t_div[ri];
			test_name     <= t_name[ri];
			exp_tx        <= b;
			exp_rx        <= b;
			exp_tx_frames <= ((t_mode[ri] == M_LOOP) || (t_mode[ri] == M_BUSY)) ? 1 : 0;
			case (t_mode[ri])
				M_LOOP, M_GLITCH: exp_rx_kind <= 2'd1;
				M_BAD:            exp_rx_kind <= 2'd2;
				default:          exp_rx_kind <= 2'd0; // Line idle
			endcase
			loop_en <= (t_mode[ri] == M_LOOP);
			@(posedge clk);
			base = strobe_cnt;

			case (t_mode[ri])
				M_LOOP: begin
					send_byte(b);
					wait_rx_strobe(base); // Can land either side of tx_empty
					wait_tx_ready();
				end
				M_BAD: begin
					bang_frame(bd, b, 1'b0);
					wait_rx_strobe(base);
				end
				M_GLITCH: begin
					glitch_len = (bd / 2) - 3; // Under the bd/2-2 limit
					if (glitch_len < 1) glitch_len = 1;
					rx_drv <= 1'b0;
					repeat (glitch_len) @(posedge clk);
					rx_drv <= 1'b1;
					repeat (bd) @(posedge clk); // Receiver back in idle
					bang_frame(bd, b, 1'b1);
					wait_rx_strobe(base);
				end
				default: begin
					send_byte(b);
					repeat (3) @(posedge clk);
					tx_data  <= ~b; // Must not reach the line
					tx_latch <= 1'b1;
					repeat (2) @(posedge clk);
					tx_latch <= 1'b0;
					wait_tx_ready();
				end
			endcase

			repeat (bd + 4) @(posedge clk); // Quiet line between rows
			row_done <= 1'b1;
			@(posedge clk);
			row_done <= 1'b0;
			ri = ri + 3'd1;
		end
		@(posedge clk);

		$display("Errors: checker %0d, timeout %0d", chk_errors, timeout_errors);
		if ((chk_errors == 0) && (timeout_errors == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: uart_core.f
rtl/uart_pkg.sv
rtl/uart_baud_timer.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_core.sv
tests/uart_core_checker.sv
tests/uart_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the uart_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=uart_core_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module uart_core_tb \
	-f uart_core.f \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG_FILE"; then
	echo "Simulation reported failure, see $LOG_FILE"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
